// File: verilog/mrd_data_pkg.sv
`default_nettype none

package mrd_data_pkg;

	localparam int NUM_BANKS = 7;
	localparam int NUM_LANES = 5;

	// bank number 7 marks a lane that maps to no bank.
	typedef logic [2:0] bank_idx_t;
	typedef logic signed [15:0] sample_t;

	// wide enough for a bank depth of up to 256 words.
	typedef logic [7:0] bank_addr_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic       wren;
		bank_addr_t wraddr;
		cplx_t      din;
	} bank_wr_t;

	typedef bank_wr_t [NUM_BANKS-1:0] bank_wr_arr_t;
	typedef bank_addr_t [NUM_BANKS-1:0] bank_rd_arr_t;
	typedef cplx_t [NUM_BANKS-1:0] bank_dout_arr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		bank_idx_t  bank_index;
		bank_addr_t bank_addr;
		cplx_t      d;
	} lane_t;

	typedef struct packed {
		logic                  valid;
		lane_t [NUM_LANES-1:0] lane;
	} lanes_t;

endpackage

`default_nettype wire

// File: verilog/mrd_ctrl_pkg.sv
`default_nettype none

package mrd_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		SINK        = 3'd1,
		WAIT_TO_RD  = 3'd2,
		RD          = 3'd3,
		WAIT_WR_END = 3'd4,
		SOURCE      = 3'd5
	} fsm_state_e;

	typedef enum logic [1:0] {
		RADIX2 = 2'd0,
		RADIX4 = 2'd1
	} radix_e;

endpackage

`default_nettype wire

// File: verilog/mrd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_fsm #(
	parameter int NUM_POINTS = 28
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     start,
	input  wire mrd_ctrl_pkg::radix_e     radix_sel,
	input  wire logic                     cursor_last,
	input  wire logic                     wr_end,
	output mrd_ctrl_pkg::fsm_state_e      state,
	output mrd_ctrl_pkg::radix_e          radix,
	output logic                          busy,
	output logic                          done
);
	import mrd_ctrl_pkg::*;

	localparam int LEFT_W = $clog2(NUM_POINTS + 2);

	fsm_state_e        state_nxt;
	logic [LEFT_W-1:0] src_left;

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (start)
					state_nxt = SINK;
			SINK:
				if (cursor_last)
					state_nxt = WAIT_TO_RD;
			WAIT_TO_RD:
				state_nxt = RD;
			RD:
				if (cursor_last)
					state_nxt = WAIT_WR_END;
			WAIT_WR_END:
				if (wr_end)
					state_nxt = SOURCE;
			SOURCE:
				if (done)
					state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	// the last output leaves the read pipeline two cycles after the
	// last source read, so the count runs two past the point count.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			radix <= RADIX2;
			src_left <= '0;
			done <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == IDLE && start)
				radix <= radix_sel;
			if (state == WAIT_WR_END && wr_end)
				src_left <= LEFT_W'(NUM_POINTS + 1);
			else if (state == SOURCE && src_left != '0)
				src_left <= src_left - 1'b1;
			done <= (state == SOURCE) && (src_left == LEFT_W'(1));
		end
	end

	assign busy = (state != IDLE);

endmodule

`default_nettype wire

// File: verilog/mrd_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_addr_gen #(
	parameter int NUM_POINTS = 28
) (
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire mrd_ctrl_pkg::fsm_state_e     state,
	input  wire mrd_ctrl_pkg::radix_e         radix,
	input  wire logic                         sink_valid,
	input  wire mrd_data_pkg::cplx_t          sink_data,
	input  wire mrd_data_pkg::bank_dout_arr_t dout,
	output mrd_data_pkg::bank_wr_arr_t        sink_wr,
	output mrd_data_pkg::bank_rd_arr_t        rd_addr,
	output mrd_data_pkg::lanes_t              rd_lanes,
	output logic                              cursor_last,
	output logic                              src_valid,
	output mrd_data_pkg::cplx_t               src_data
);
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	localparam int CNT_W = $clog2(NUM_POINTS + 1);

	bank_idx_t             cur_bank;
	bank_addr_t            cur_addr;
	logic [CNT_W-1:0]      pt_cnt;
	logic                  phase_end;
	logic                  active;
	logic                  req;
	logic [2:0]            grp;
	lane_t [NUM_LANES-1:0] req_loc;
	lane_t                 next_loc;
	logic                  loc_valid;
	lane_t [NUM_LANES-1:0] loc_lane;
	logic                  src_req_q;
	logic                  lanes_valid;
	lane_t [NUM_LANES-1:0] lanes_q;

	// steps a point location forward without a divider; ofs never exceeds a bank count.
	function automatic lane_t step_loc(bank_idx_t b, bank_addr_t a, logic [2:0] ofs);
		lane_t      l;
		logic [3:0] s;
		s = {1'b0, b} + {1'b0, ofs};
		l = '0;
		if (s >= 4'(NUM_BANKS))
		begin
			l.bank_index = bank_idx_t'(s - 4'(NUM_BANKS));
			l.bank_addr = a + 8'd1;
		end
		else
		begin
			l.bank_index = bank_idx_t'(s);
			l.bank_addr = a;
		end
		return l;
	endfunction

	assign active = (state == SINK) || (state == RD) || (state == SOURCE);
	assign req = !phase_end && ((state == SINK) ? sink_valid : active);
	assign grp = (state == RD) ? ((radix == RADIX4) ? 3'd4 : 3'd2) : 3'd1;
	assign cursor_last = req && (int'(pt_cnt) + int'(grp) == NUM_POINTS);
	assign next_loc = step_loc(cur_bank, cur_addr, grp);

	always_comb
	begin
		rd_addr = '0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			req_loc[i] = step_loc(cur_bank, cur_addr, 3'(i));
			if (3'(i) >= grp)
				req_loc[i].bank_index = 3'd7;
			else
				rd_addr[req_loc[i].bank_index] = req_loc[i].bank_addr;
		end
	end

	always_comb
	begin
		for (int k = 0; k < NUM_BANKS; k++)
		begin
			sink_wr[k].wren = req && (state == SINK) && (cur_bank == bank_idx_t'(k));
			sink_wr[k].wraddr = cur_addr;
			sink_wr[k].din = sink_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// the cursor starts over in every state between two phases.
	always_ff @(posedge clk)
	begin
		if (!rst_n || !active)
		begin
			cur_bank <= '0;
			cur_addr <= '0;
			pt_cnt <= '0;
			phase_end <= 1'b0;
		end
		else if (req)
		begin
			cur_bank <= next_loc.bank_index;
			cur_addr <= next_loc.bank_addr;
			pt_cnt <= pt_cnt + CNT_W'(grp);
			if (cursor_last)
				phase_end <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			loc_valid <= 1'b0;
			src_req_q <= 1'b0;
			lanes_valid <= 1'b0;
			src_valid <= 1'b0;
		end
		else
		begin
			loc_valid <= req && (state == RD);
			src_req_q <= req && (state == SOURCE);
			lanes_valid <= loc_valid;
			src_valid <= src_req_q;
		end
	end

	// locations wait one cycle for the registered bank read.
	always_ff @(posedge clk)
	begin
		loc_lane <= req_loc;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			lanes_q[i].bank_index <= loc_lane[i].bank_index;
			lanes_q[i].bank_addr <= loc_lane[i].bank_addr;
			if (loc_lane[i].bank_index < 3'(NUM_BANKS))
				lanes_q[i].d <= dout[loc_lane[i].bank_index];
			else
				lanes_q[i].d <= '0;
		end
	end

	assign rd_lanes = {lanes_valid, lanes_q};
	assign src_data = lanes_q[0].d;

endmodule

`default_nettype wire

// File: verilog/mrd_banks.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_banks #(
	parameter int BANK_DEPTH = 16
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire mrd_ctrl_pkg::fsm_state_e   state,
	input  wire mrd_data_pkg::bank_wr_arr_t sink_wr,
	input  wire mrd_data_pkg::bank_wr_arr_t bf_wr,
	input  wire mrd_data_pkg::bank_rd_arr_t rd_addr,
	output mrd_data_pkg::bank_dout_arr_t    dout
);
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	localparam int AW = $clog2(BANK_DEPTH);

	bank_wr_arr_t wr_sel;

	// samples are stored while sinking, butterfly results at all other times.
	assign wr_sel = (state == SINK) ? sink_wr : bf_wr;

	for (genvar k = 0; k < NUM_BANKS; k++)
	begin : g_bank
		cplx_t mem [BANK_DEPTH];
		cplx_t rd_q;

		// a read of the address being written returns the old word.
		always_ff @(posedge clk)
		begin
			if (rst_n && wr_sel[k].wren)
				mem[wr_sel[k].wraddr[AW-1:0]] <= wr_sel[k].din;
			rd_q <= mem[rd_addr[k][AW-1:0]];
		end

		assign dout[k] = rd_q;
	end

endmodule

`default_nettype wire

// File: verilog/mrd_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_butterfly (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire mrd_ctrl_pkg::radix_e radix,
	input  wire mrd_data_pkg::lanes_t rd_lanes,
	output mrd_data_pkg::lanes_t      bf_lanes
);
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	// two guard bits hold a four-term sum.
	typedef logic signed [17:0] acc_t;

	typedef struct packed {
		acc_t re;
		acc_t im;
	} wide_t;

	wide_t                 w0;
	wide_t                 w1;
	wide_t                 w2;
	wide_t                 w3;
	lane_t [NUM_LANES-1:0] res;
	logic                  out_valid;
	lane_t [NUM_LANES-1:0] out_lane;

	function automatic wide_t widen(cplx_t x);
		wide_t w;
		w.re = acc_t'(x.re);
		w.im = acc_t'(x.im);
		return w;
	endfunction

	function automatic sample_t scale(acc_t v, logic r4);
		return r4 ? sample_t'(v >>> 2) : sample_t'(v >>> 1);
	endfunction

	// bank locations are copied through, so results overwrite their inputs.
	always_comb
	begin
		w0 = widen(rd_lanes.lane[0].d);
		w1 = widen(rd_lanes.lane[1].d);
		w2 = widen(rd_lanes.lane[2].d);
		w3 = widen(rd_lanes.lane[3].d);
		res = rd_lanes.lane;
		if (radix == RADIX4)
		begin
			res[0].d.re = scale(w0.re + w1.re + w2.re + w3.re, 1'b1);
			res[0].d.im = scale(w0.im + w1.im + w2.im + w3.im, 1'b1);
			res[1].d.re = scale(w0.re + w1.im - w2.re - w3.im, 1'b1);
			res[1].d.im = scale(w0.im - w1.re - w2.im + w3.re, 1'b1);
			res[2].d.re = scale(w0.re - w1.re + w2.re - w3.re, 1'b1);
			res[2].d.im = scale(w0.im - w1.im + w2.im - w3.im, 1'b1);
			res[3].d.re = scale(w0.re - w1.im - w2.re + w3.im, 1'b1);
			res[3].d.im = scale(w0.im + w1.re - w2.im - w3.re, 1'b1);
		end
		else
		begin
			res[0].d.re = scale(w0.re + w1.re, 1'b0);
			res[0].d.im = scale(w0.im + w1.im, 1'b0);
			res[1].d.re = scale(w0.re - w1.re, 1'b0);
			res[1].d.im = scale(w0.im - w1.im, 1'b0);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= rd_lanes.valid;
	end

	always_ff @(posedge clk)
	begin
		out_lane <= res;
	end

	assign bf_lanes = {out_valid, out_lane};

endmodule

`default_nettype wire

// File: verilog/mrd_fsmrd_wr.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_fsmrd_wr (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire mrd_ctrl_pkg::fsm_state_e fsm,
	input  wire mrd_data_pkg::lanes_t     in_lanes,
	output mrd_data_pkg::bank_wr_arr_t    wr,
	output logic                          wr_end
);
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	logic wr_ongoing;

	for (genvar k = 0; k < NUM_BANKS; k++)
	begin : g_port
		logic       hit;
		bank_addr_t hit_addr;
		cplx_t      hit_d;
		logic       wren_q;
		bank_addr_t addr_q;
		cplx_t      din_q;

		// scanning downward leaves the lowest matching lane in place.
		always_comb
		begin
			hit = 1'b0;
			hit_addr = '0;
			hit_d = '0;
			for (int i = NUM_LANES - 1; i >= 0; i--)
			begin
				if (in_lanes.lane[i].bank_index == bank_idx_t'(k))
				begin
					hit = 1'b1;
					hit_addr = in_lanes.lane[i].bank_addr;
					hit_d = in_lanes.lane[i].d;
				end
			end
		end

		always_ff @(posedge clk)
		begin
			if (!rst_n)
				wren_q <= 1'b0;
			else
				wren_q <= hit & in_lanes.valid;
		end

		always_ff @(posedge clk)
		begin
			addr_q <= hit_addr;
			din_q <= hit_d;
		end

		assign wr[k] = {wren_q, addr_q, din_q};
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ongoing <= 1'b0;
			wr_end <= 1'b0;
		end
		else
		begin
			wr_ongoing <= (fsm == RD || fsm == WAIT_WR_END) ? in_lanes.valid : 1'b0;
			wr_end <= wr_ongoing & ~in_lanes.valid;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mrd_top.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_top #(
	parameter int BANK_DEPTH = 16,
	parameter int NUM_POINTS = 28
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire mrd_ctrl_pkg::radix_e radix_sel,
	input  wire logic                 sink_valid,
	input  wire mrd_data_pkg::cplx_t  sink_data,
	output logic                      busy,
	output logic                      src_valid,
	output mrd_data_pkg::cplx_t       src_data,
	output logic                      done
);
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	fsm_state_e     state;
	radix_e         radix;
	logic           cursor_last;
	logic           wr_end;
	bank_wr_arr_t   sink_wr;
	bank_wr_arr_t   bf_wr;
	bank_rd_arr_t   rd_addr;
	bank_dout_arr_t dout;
	lanes_t         rd_lanes;
	lanes_t         bf_lanes;

	mrd_fsm #(.NUM_POINTS(NUM_POINTS)) fsm_i (
		.clk(clk), .rst_n(rst_n), .start(start), .radix_sel(radix_sel),
		.cursor_last(cursor_last), .wr_end(wr_end), .state(state), .radix(radix),
		.busy(busy), .done(done)
	);

	mrd_addr_gen #(.NUM_POINTS(NUM_POINTS)) addr_gen_i (
		.clk(clk), .rst_n(rst_n), .state(state), .radix(radix),
		.sink_valid(sink_valid), .sink_data(sink_data), .dout(dout),
		.sink_wr(sink_wr), .rd_addr(rd_addr), .rd_lanes(rd_lanes),
		.cursor_last(cursor_last), .src_valid(src_valid), .src_data(src_data)
	);

	mrd_banks #(.BANK_DEPTH(BANK_DEPTH)) banks_i (
		.clk(clk), .rst_n(rst_n), .state(state), .sink_wr(sink_wr),
		.bf_wr(bf_wr), .rd_addr(rd_addr), .dout(dout)
	);

	mrd_butterfly butterfly_i (
		.clk(clk), .rst_n(rst_n), .radix(radix), .rd_lanes(rd_lanes),
		.bf_lanes(bf_lanes)
	);

	mrd_fsmrd_wr fsmrd_wr_i (
		.clk(clk), .rst_n(rst_n), .fsm(state), .in_lanes(bf_lanes),
		.wr(bf_wr), .wr_end(wr_end)
	);

endmodule

`default_nettype wire

// File: test/mrd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_tb;
	import mrd_data_pkg::*;
	import mrd_ctrl_pkg::*;

	localparam int BANK_DEPTH = 16;
	localparam int NUM_POINTS = 28;
	localparam int TIMEOUT = 6 * (3 * NUM_POINTS + 40);

	typedef cplx_t cplx_q_t [$];

	logic    clk;
	logic    rst_n;
	logic    start;
	radix_e  radix_sel;
	logic    sink_valid;
	cplx_t   sink_data;
	logic    busy;
	logic    src_valid;
	cplx_t   src_data;
	logic    done;
	int      errors;
	int      cycles;
	cplx_q_t ramp_in;
	cplx_q_t ramp_out;
	cplx_q_t rand_in;
	cplx_q_t rand_out;

	mrd_top #(.BANK_DEPTH(BANK_DEPTH), .NUM_POINTS(NUM_POINTS)) dut_i (
		.clk(clk), .rst_n(rst_n), .start(start), .radix_sel(radix_sel),
		.sink_valid(sink_valid), .sink_data(sink_data), .busy(busy),
		.src_valid(src_valid), .src_data(src_data), .done(done)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout after %0d cycles, the DUT never finished its runs", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_sample(input string name, input cplx_t exp, input cplx_t act);
		if (exp !== act)
		begin
			$display("Mismatch %s: expected (%0d, %0d), actual (%0d, %0d)",
				name, exp.re, exp.im, act.re, act.im);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	function automatic cplx_t make_cplx(int re, int im, int sh);
		cplx_t c;
		c.re = sample_t'(re >>> sh);
		c.im = sample_t'(im >>> sh);
		return c;
	endfunction

	// groups of consecutive points, scaled by log2 of the radix.
	function automatic cplx_q_t model_fft(radix_e r, cplx_q_t x);
		cplx_q_t y;
		int      ar, ai, br, bi, cr, ci, dr, di;
		y = {};
		if (r == RADIX4)
		begin
			for (int g = 0; g < x.size(); g += 4)
			begin
				ar = x[g].re;
				ai = x[g].im;
				br = x[g+1].re;
				bi = x[g+1].im;
				cr = x[g+2].re;
				ci = x[g+2].im;
				dr = x[g+3].re;
				di = x[g+3].im;
				y.push_back(make_cplx(ar + br + cr + dr, ai + bi + ci + di, 2));
				y.push_back(make_cplx(ar + bi - cr - di, ai - br - ci + dr, 2));
				y.push_back(make_cplx(ar - br + cr - dr, ai - bi + ci - di, 2));
				y.push_back(make_cplx(ar - bi - cr + di, ai + br - ci - dr, 2));
			end
		end
		else
		begin
			for (int g = 0; g < x.size(); g += 2)
			begin
				ar = x[g].re;
				ai = x[g].im;
				br = x[g+1].re;
				bi = x[g+1].im;
				y.push_back(make_cplx(ar + br, ai + bi, 1));
				y.push_back(make_cplx(ar - br, ai - bi, 1));
			end
		end
		return y;
	endfunction

	function automatic cplx_q_t random_block();
		cplx_q_t x;
		cplx_t   c;
		x = {};
		for (int i = 0; i < NUM_POINTS; i++)
		begin
			c.re = sample_t'($urandom);
			c.im = sample_t'($urandom);
			x.push_back(c);
		end
		return x;
	endfunction

	task automatic compare_runs(input string name, input cplx_q_t exp, input cplx_q_t act);
		if (exp.size() != act.size())
		begin
			$display("%s: expected %0d output samples but got %0d", name, exp.size(),
				act.size());
			errors++;
		end
		else
			for (int i = 0; i < exp.size(); i++)
				check_sample($sformatf("%s[%0d]", name, i), exp[i], act[i]);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// a poke pulses start and flips radix_sel halfway through the sink.
	task automatic run_fft(input string name, input radix_e r, input cplx_q_t x,
		input bit gaps, input bit poke, output cplx_q_t y);
		int idx;
		bit seen_done;
		y = {};
		seen_done = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		radix_sel <= r;
		@(posedge clk);
		start <= 1'b0;
		idx = 0;
		while (idx < x.size())
		begin
			if (gaps && ($urandom % 3 == 0))
			begin
				sink_valid <= 1'b0;
				@(posedge clk);
			end
			sink_valid <= 1'b1;
			sink_data <= x[idx];
			start <= poke && (idx == x.size() / 2);
			radix_sel <= (poke && idx == x.size() / 2) ? ((r == RADIX2) ? RADIX4 : RADIX2) : r;
			idx++;
			@(posedge clk);
		end
		sink_valid <= 1'b0;
		sink_data <= '0;
		start <= poke;
		@(posedge clk);
		start <= 1'b0;
		while (!seen_done)
		begin
			@(negedge clk);
			check_bit({name, " busy while running"}, 1'b1, busy);
			if (src_valid)
				y.push_back(src_data);
			if (done)
			begin
				seen_done = 1'b1;
				check_bit({name, " done with last output"}, 1'b1, src_valid);
			end
		end
		@(negedge clk);
		check_bit({name, " busy after done"}, 1'b0, busy);
		check_bit({name, " src_valid after done"}, 1'b0, src_valid);
		check_bit({name, " done after done"}, 1'b0, done);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic idle_after_reset();
		repeat (8)
		begin
			@(negedge clk);
			check_bit("idle busy", 1'b0, busy);
			check_bit("idle src_valid", 1'b0, src_valid);
			check_bit("idle done", 1'b0, done);
		end
	endtask

	task automatic radix2_ramp();
		cplx_t c;
		ramp_in = {};
		for (int i = 0; i < NUM_POINTS; i++)
		begin
			c.re = sample_t'(i * 64 - 800);
			c.im = sample_t'(300 - i * 25);
			ramp_in.push_back(c);
		end
		run_fft("radix2 ramp", RADIX2, ramp_in, 1'b0, 1'b0, ramp_out);
		compare_runs("radix2 ramp", model_fft(RADIX2, ramp_in), ramp_out);
	endtask

	task automatic radix4_random();
		rand_in = random_block();
		run_fft("radix4 random", RADIX4, rand_in, 1'b0, 1'b0, rand_out);
		compare_runs("radix4 random", model_fft(RADIX4, rand_in), rand_out);
	endtask

	task automatic sink_gaps();
		cplx_q_t y;
		run_fft("sink gaps", RADIX4, rand_in, 1'b1, 1'b0, y);
		compare_runs("sink gaps", model_fft(RADIX4, rand_in), y);
	endtask

	task automatic back_to_back();
		cplx_q_t x1;
		cplx_q_t x2;
		cplx_q_t y1;
		cplx_q_t y2;
		x1 = random_block();
		x2 = random_block();
		run_fft("back to back r4", RADIX4, x1, 1'b0, 1'b0, y1);
		run_fft("back to back r2", RADIX2, x2, 1'b0, 1'b0, y2);
		compare_runs("back to back r4", model_fft(RADIX4, x1), y1);
		compare_runs("back to back r2", model_fft(RADIX2, x2), y2);
	endtask

	task automatic start_while_busy();
		cplx_q_t y;
		run_fft("start while busy", RADIX2, ramp_in, 1'b0, 1'b1, y);
		compare_runs("start while busy", model_fft(RADIX2, ramp_in), y);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		radix_sel = RADIX2;
		sink_valid = 1'b0;
		sink_data = '0;
		errors = 0;
		cycles = 0;
		void'($urandom(32'h6b21b33b));
		apply_reset();
		idle_after_reset();
		radix2_ramp();
		radix4_random();
		sink_gaps();
		back_to_back();
		start_while_busy();
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
verilog/mrd_data_pkg.sv
verilog/mrd_ctrl_pkg.sv
verilog/mrd_fsm.sv
verilog/mrd_addr_gen.sv
verilog/mrd_banks.sv
verilog/mrd_butterfly.sv
verilog/mrd_fsmrd_wr.sv
verilog/mrd_top.sv
test/mrd_tb.sv

// File: Bender.yml
package:
  name: mrd_fft_engine

sources:
  - files:
      - verilog/mrd_data_pkg.sv
      - verilog/mrd_ctrl_pkg.sv
      - verilog/mrd_fsm.sv
      - verilog/mrd_addr_gen.sv
      - verilog/mrd_banks.sv
      - verilog/mrd_butterfly.sv
      - verilog/mrd_fsmrd_wr.sv
      - verilog/mrd_top.sv
  - target: test
    files:
      - test/mrd_tb.sv
